// ==== source/isaPkg.sv ====
/* isaPkg
   MIPS instruction field types and the opcode, funct and rt-field encodings */

package isaPkg;

  typedef logic [31:0] instrWord;
  typedef logic [4:0]  regIdx;    // architectural register index
  typedef logic [5:0]  opcodeT;
  typedef logic [5:0]  functT;
  typedef logic [4:0]  shamtT;
  typedef logic [15:0] immT;

  // opcodes of the supported set
  localparam opcodeT opRtype  = 6'b000000;
  localparam opcodeT opRegimm = 6'b000001; // bgez and bltz, told apart by rt
  localparam opcodeT opJ      = 6'b000010;
  localparam opcodeT opJal    = 6'b000011;
  localparam opcodeT opBeq    = 6'b000100;
  localparam opcodeT opBne    = 6'b000101;
  localparam opcodeT opAddiu  = 6'b001001;
  localparam opcodeT opSlti   = 6'b001010;
  localparam opcodeT opSltiu  = 6'b001011;
  localparam opcodeT opAndi   = 6'b001100;
  localparam opcodeT opOri    = 6'b001101;
  localparam opcodeT opXori   = 6'b001110;
  localparam opcodeT opLui    = 6'b001111;
  localparam opcodeT opLw     = 6'b100011;
  localparam opcodeT opSw     = 6'b101011;

  // funct codes under opRtype
  localparam functT fnSll  = 6'b000000;
  localparam functT fnSrl  = 6'b000010;
  localparam functT fnSra  = 6'b000011;
  localparam functT fnJr   = 6'b001000;
  localparam functT fnAddu = 6'b100001;
  localparam functT fnSubu = 6'b100011;
  localparam functT fnAnd  = 6'b100100;
  localparam functT fnOr   = 6'b100101;
  localparam functT fnXor  = 6'b100110;
  localparam functT fnSlt  = 6'b101010;
  localparam functT fnSltu = 6'b101011;

  localparam regIdx rtBltz  = 5'b00000; // regimm rt field
  localparam regIdx rtBgez  = 5'b00001;
  localparam regIdx linkReg = 5'd31;    // jal destination

endpackage

// ==== source/dispatchPkg.sv ====
/* dispatchPkg
   Tomasulo-side types, instruction classes and the ALU and branch op codes */

package dispatchPkg;

  typedef logic [31:0] dataWord;
  typedef logic [4:0]  robTag;    // 0 means no producer, operand is ready
  typedef logic [5:0]  aluOpT;
  typedef logic [1:0]  branchOpT;

  // alu operation codes as the ALU station expects them
  localparam aluOpT aluAdd  = 6'b000000;
  localparam aluOpT aluAnd  = 6'b000001;
  localparam aluOpT aluOr   = 6'b000010;
  localparam aluOpT aluXor  = 6'b000011;
  localparam aluOpT aluSub  = 6'b000100;
  localparam aluOpT aluSlt  = 6'b010100;
  localparam aluOpT aluSltu = 6'b011100;
  localparam aluOpT aluSll  = 6'b100000;
  localparam aluOpT aluSrl  = 6'b100010;
  localparam aluOpT aluSra  = 6'b100011;

  // jump kind for the ROB
  localparam branchOpT brNone = 2'b00;
  localparam branchOpT brJal  = 2'b01;
  localparam branchOpT brJr   = 2'b10;
  localparam branchOpT brJ    = 2'b11;

  localparam dataWord jalLinkOffset = 32'd8; // link value is pc + 8

  typedef enum logic [3:0] {
    clsAluReg, clsAluImm, clsLui, clsShift,
    clsBranchCmp, clsBranchZero,
    clsJump, clsJumpReg, clsJumpLink,
    clsLoad, clsStore,
    clsNone
  } instrClass;

  typedef enum logic {stIdle, stRecover} issueState;

endpackage

// ==== source/instrDecoder.sv ====
/* instrDecoder
   classifies one MIPS word and derives aluOp, branchOp, destination and immediates */
`timescale 1ns/1ps

module instrDecoder import isaPkg::*, dispatchPkg::*; (
  input  instrWord  instr,
  output instrClass instClass,
  output aluOpT     aluOp,
  output branchOpT  branchOp,
  output regIdx     writeReg,
  output dataWord   immExt,
  output immT       addrImm
);

  opcodeT op;
  functT  funct;
  regIdx  rtField;
  regIdx  rdField;
  immT    imm;
  logic   signExt; // sign or zero extension of imm

  assign op      = instr[31:26];
  assign rtField = instr[20:16];
  assign rdField = instr[15:11];
  assign imm     = instr[15:0];
  assign funct   = instr[5:0];

  // one class per word, unknown encodings fall to clsNone
  always_comb
  begin
    case (op)
      opRtype:
        case (funct)
          fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt, fnSltu: instClass = clsAluReg;
          fnSll, fnSrl, fnSra: instClass = clsShift;
          fnJr:    instClass = clsJumpReg;
          default: instClass = clsNone;
        endcase
      opAddiu, opAndi, opOri, opXori, opSlti, opSltiu: instClass = clsAluImm;
      opLui:        instClass = clsLui;
      opBeq, opBne: instClass = clsBranchCmp;
      opRegimm:     instClass = (rtField == rtBgez || rtField == rtBltz) ? clsBranchZero
                                                                          : clsNone;
      opJ:          instClass = clsJump;
      opJal:        instClass = clsJumpLink;
      opLw:         instClass = clsLoad;
      opSw:         instClass = clsStore;
      default:      instClass = clsNone;
    endcase
  end

  always_comb
  begin
    aluOp = aluAdd; // addu, addiu, lui, jal and everything outside the alu
    if (op == opRtype)
    begin
      case (funct)
        fnSubu:  aluOp = aluSub;
        fnAnd:   aluOp = aluAnd;
        fnOr:    aluOp = aluOr;
        fnXor:   aluOp = aluXor;
        fnSlt:   aluOp = aluSlt;
        fnSltu:  aluOp = aluSltu;
        fnSll:   aluOp = aluSll;
        fnSrl:   aluOp = aluSrl;
        fnSra:   aluOp = aluSra;
        default: aluOp = aluAdd;
      endcase
    end
    else
    begin
      case (op)
        opAndi:  aluOp = aluAnd;
        opOri:   aluOp = aluOr;
        opXori:  aluOp = aluXor;
        opSlti:  aluOp = aluSlt;
        opSltiu: aluOp = aluSltu;
        default: aluOp = aluAdd;
      endcase
    end
  end

  always_comb
  begin
    case (instClass)
      clsAluReg, clsShift:         writeReg = rdField;
      clsAluImm, clsLui, clsLoad:  writeReg = rtField;
      clsJumpLink:                 writeReg = linkReg;
      default:                     writeReg = '0; // nothing written
    endcase
  end

  assign branchOp = (instClass == clsJumpLink) ? brJal :
                    (instClass == clsJumpReg)  ? brJr  :
                    (instClass == clsJump)     ? brJ   : brNone;

  // arithmetic immediates, branch offsets and address offsets are signed
  assign signExt = (op == opAddiu) || (op == opSlti) || (op == opSltiu) ||
                   (instClass == clsBranchCmp) || (instClass == clsBranchZero) ||
                   (instClass == clsLoad) || (instClass == clsStore);

  assign immExt = (instClass == clsLui) ? {imm, 16'h0000} :
                  signExt               ? {{16{imm[15]}}, imm} : {16'h0000, imm};

  assign addrImm = (instClass == clsLoad || instClass == clsStore) ? imm : '0; // lw/sw offset

endmodule

// ==== source/sourceResolver.sv ====
/* sourceResolver
   turns one source register into a ready value or a pending ROB tag, with CDB forwarding */
`timescale 1ns/1ps

module sourceResolver import dispatchPkg::*; (
  input  robTag   reorder,   // producer tag from the status file
  input  dataWord regData,
  input  logic    robReady,
  input  dataWord robValue,
  input  logic    cdbValid,
  input  robTag   cdbTag,
  input  dataWord cdbValue,
  output dataWord value,
  output robTag   tag
);

  always_comb
  begin
    value = '0; // don't-care while pending
    tag   = reorder;
    if (reorder == '0)
    begin
      value = regData; // no producer in flight
      tag   = '0;
    end
    else if (robReady)
    begin
      value = robValue; // done but not yet committed
      tag   = '0;
    end
    else if (cdbValid && cdbTag == reorder)
    begin
      value = cdbValue; // written back this very cycle
      tag   = '0;
    end
  end

endmodule

// ==== source/operandSelect.sv ====
/* operandSelect
   builds Vj/Qj and Vk/Qk for the reservation station from the class and resolved sources */
`timescale 1ns/1ps

module operandSelect import isaPkg::*, dispatchPkg::*; (
  input  instrClass instClass,
  input  instrWord  instr,
  input  dataWord   pc,
  input  dataWord   immExt,
  input  robTag     rsReorder,
  input  robTag     rtReorder,
  input  dataWord   rsData,
  input  dataWord   rtData,
  input  logic      rsRobReady,
  input  dataWord   rsRobValue,
  input  logic      rtRobReady,
  input  dataWord   rtRobValue,
  input  logic      cdbValid,
  input  robTag     cdbTag,
  input  dataWord   cdbValue,
  output dataWord   vj,
  output dataWord   vk,
  output robTag     qj,
  output robTag     qk
);

  shamtT   shamt;
  dataWord rsValue;
  dataWord rtValue;
  robTag   rsTag;
  robTag   rtTag;

  assign shamt = instr[10:6];

  // one resolver per ROB read port
  sourceResolver rsSource (
    .reorder (rsReorder), .regData (rsData), .robReady (rsRobReady), .robValue (rsRobValue),
    .cdbValid (cdbValid), .cdbTag (cdbTag), .cdbValue (cdbValue),
    .value (rsValue), .tag (rsTag)
  );

  sourceResolver rtSource (
    .reorder (rtReorder), .regData (rtData), .robReady (rtRobReady), .robValue (rtRobValue),
    .cdbValid (cdbValid), .cdbTag (cdbTag), .cdbValue (cdbValue),
    .value (rtValue), .tag (rtTag)
  );

  always_comb
  begin
    qj = '0; // constants never wait
    case (instClass)
      clsAluReg, clsAluImm, clsBranchCmp, clsBranchZero, clsJumpReg, clsLoad, clsStore:
      begin
        vj = rsValue;
        qj = rsTag;
      end
      clsShift:    vj = {27'b0, shamt}; // shift amount in the rs slot
      clsJumpLink: vj = pc;
      default:     vj = '0;              // lui, j, none
    endcase
  end

  always_comb
  begin
    qk = '0;
    case (instClass)
      clsAluReg, clsShift, clsBranchCmp, clsStore:
      begin
        vk = rtValue; // sw data rides in vk
        qk = rtTag;
      end
      clsAluImm, clsLui: vk = immExt;
      clsJumpLink:       vk = jalLinkOffset; // alu adds pc + 8
      default:           vk = '0;
    endcase
  end

endmodule

// ==== source/issueControl.sv ====
/* issueControl
   rollback recovery state, station full selection and the one-cycle issue strobes */
`timescale 1ns/1ps

module issueControl import dispatchPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  instrClass instClass,
  input  logic [4:0] writeReg,
  input  robTag     qj,
  input  logic      stall,
  input  logic      rollback,
  input  logic      robFull,
  input  logic      aluFull,
  input  logic      branchFull,
  input  logic      loadFull,
  input  logic      storeFull,
  output logic      robIssue,
  output logic      regStatIssue,
  output logic      aluIssue,
  output logic      branchIssue,
  output logic      loadIssue,
  output logic      storeIssue,
  output logic      jrStall,
  output logic      robEntryReady,
  output logic      rsBusy
);

  issueState state;
  logic      selFull;  // full flag of the target station
  logic      aluClass;
  logic      issueOk;

  // rollback holds off issue for its own cycle and the one after
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      state <= stRecover; // come out of reset blocked
    else
      state <= rollback ? stRecover : stIdle;
  end

  assign aluClass = (instClass == clsAluReg) || (instClass == clsAluImm) ||
                    (instClass == clsLui) || (instClass == clsShift);

  always_comb
  begin
    case (instClass)
      clsAluReg, clsAluImm, clsLui, clsShift: selFull = aluFull;
      clsBranchCmp, clsBranchZero:            selFull = branchFull;
      clsLoad:                                selFull = loadFull;
      clsStore:                               selFull = storeFull;
      default:                                selFull = 1'b0; // jumps go to the ROB only
    endcase
  end

  assign jrStall = (instClass == clsJumpReg) && (qj != '0); // target not known yet

  assign issueOk = !stall && !robFull && !selFull && !rollback && (state == stIdle) &&
                   !jrStall && (instClass != clsNone);

  assign robIssue     = issueOk; // every issued op takes a ROB entry
  assign aluIssue     = issueOk && (aluClass || instClass == clsJumpLink) && (writeReg != '0);
  assign branchIssue  = issueOk && (instClass == clsBranchCmp || instClass == clsBranchZero);
  assign loadIssue    = issueOk && (instClass == clsLoad) && (writeReg != '0);
  assign storeIssue   = issueOk && (instClass == clsStore);
  assign regStatIssue = issueOk && (aluClass || instClass == clsJumpLink ||
                                    instClass == clsLoad);

  // ROB needs no CDB result when no station got the op
  assign robEntryReady = ~(aluIssue | branchIssue | loadIssue | storeIssue);
  assign rsBusy        = selFull | robFull;

endmodule

// ==== source/dispatchUnit.sv ====
/* dispatchUnit
   decode and dispatch stage of the Tomasulo core, decoder plus operand select plus issue */
`timescale 1ns/1ps

module dispatchUnit import dispatchPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic [31:0] instr,
  input  dataWord    pc,
  input  logic       stall,
  input  logic       rollback,
  input  logic       robFull,
  input  logic       aluFull,
  input  logic       branchFull,
  input  logic       loadFull,
  input  logic       storeFull,
  input  robTag      rsReorder,   // status file lookup
  input  robTag      rtReorder,
  input  dataWord    rsData,      // register file lookup
  input  dataWord    rtData,
  input  logic       rsRobReady,  // ROB lookup by reorder tag
  input  dataWord    rsRobValue,
  input  logic       rtRobReady,
  input  dataWord    rtRobValue,
  input  logic       cdbValid,
  input  robTag      cdbTag,
  input  dataWord    cdbValue,
  output logic [4:0] rs,
  output logic [4:0] rt,
  output logic       robIssue,
  output logic       regStatIssue,
  output logic       aluIssue,
  output logic       branchIssue,
  output logic       loadIssue,
  output logic       storeIssue,
  output logic       jrStall,
  output logic       robEntryReady,
  output logic       rsBusy,
  output dataWord    vj,
  output dataWord    vk,
  output robTag      qj,
  output robTag      qk,
  output logic [15:0] addrImm,
  output aluOpT      aluOp,
  output branchOpT   branchOp,
  output logic [4:0] writeReg
);

  instrClass instClass;
  dataWord   immExt;

  assign rs = instr[25:21]; // raw fields index the register and status files
  assign rt = instr[20:16];

  instrDecoder i_instrDecoder (
    .instr (instr), .instClass (instClass), .aluOp (aluOp), .branchOp (branchOp),
    .writeReg (writeReg), .immExt (immExt), .addrImm (addrImm)
  );

  operandSelect i_operandSelect (
    .instClass (instClass), .instr (instr), .pc (pc), .immExt (immExt),
    .rsReorder (rsReorder), .rtReorder (rtReorder), .rsData (rsData), .rtData (rtData),
    .rsRobReady (rsRobReady), .rsRobValue (rsRobValue),
    .rtRobReady (rtRobReady), .rtRobValue (rtRobValue),
    .cdbValid (cdbValid), .cdbTag (cdbTag), .cdbValue (cdbValue),
    .vj (vj), .vk (vk), .qj (qj), .qk (qk)
  );

  // qj feeds back for the jr stall
  issueControl i_issueControl (
    .clk (clk), .rstN (rstN), .instClass (instClass), .writeReg (writeReg), .qj (qj),
    .stall (stall), .rollback (rollback), .robFull (robFull), .aluFull (aluFull),
    .branchFull (branchFull), .loadFull (loadFull), .storeFull (storeFull),
    .robIssue (robIssue), .regStatIssue (regStatIssue), .aluIssue (aluIssue),
    .branchIssue (branchIssue), .loadIssue (loadIssue), .storeIssue (storeIssue),
    .jrStall (jrStall), .robEntryReady (robEntryReady), .rsBusy (rsBusy)
  );

endmodule

// ==== test/dispatchUnit_assertions.sv ====
/* dispatchUnitAssertions
   bound checker for decode, operand resolution, issue gating and routing */
`timescale 1ns/1ps

module dispatchUnitAssertions import isaPkg::*, dispatchPkg::*; (
  input logic     clk,
  input logic     rstN,
  input instrWord instr,
  input dataWord  pc,
  input logic     stall,
  input logic     rollback,
  input logic     robFull, aluFull, branchFull, loadFull, storeFull,
  input robTag    rsReorder, rtReorder,
  input dataWord  rsData, rtData,
  input logic     rsRobReady, rtRobReady,
  input dataWord  rsRobValue, rtRobValue,
  input logic     cdbValid,
  input robTag    cdbTag,
  input dataWord  cdbValue,
  input regIdx    rs, rt,
  input logic     robIssue, regStatIssue, aluIssue, branchIssue, loadIssue, storeIssue,
  input logic     jrStall,
  input logic     robEntryReady,
  input logic     rsBusy,
  input dataWord  vj,
  input dataWord  vk,
  input robTag    qj, qk,
  input immT      addrImm,
  input aluOpT    aluOp,
  input branchOpT branchOp,
  input regIdx    writeReg
);

  int         errCount = 0; // read by the testbench at the end
  opcodeT     op;
  functT      fn;
  immT        imm;
  instrClass  expClass;
  aluOpT      expAluOp;
  branchOpT   expBranchOp;
  regIdx      expWriteReg;
  dataWord    expImm;
  dataWord    expRsVal, expRtVal;
  robTag      expRsTag, expRtTag;
  robTag      expQj, expQk;  // unused slots carry tag 0
  logic       aluCls, brCls, usesRs, usesRt;
  logic       expSelFull, expJrStall, expIssue, expRegStat;
  logic       prevBlock;    // rollback seen last cycle, or still coming out of reset
  logic [3:0] stations, expStations; // alu, branch, load, store

  task automatic countFailure(input string sigName, input logic [31:0] got,
                              input logic [31:0] expected);
    errCount++;
    $error("CHECK FAILED t=%0t %s got %0h expected %0h", $time, sigName, got, expected);
  endtask

  assign op  = instr[31:26];
  assign fn  = instr[5:0];
  assign imm = instr[15:0];

  always_comb
  begin
    expClass = clsNone;
    case (op)
      opRtype:
        if (fn inside {fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt, fnSltu})
          expClass = clsAluReg;
        else if (fn inside {fnSll, fnSrl, fnSra})
          expClass = clsShift;
        else if (fn == fnJr)
          expClass = clsJumpReg;
      opAddiu, opAndi, opOri, opXori, opSlti, opSltiu: expClass = clsAluImm;
      opLui:        expClass = clsLui;
      opBeq, opBne: expClass = clsBranchCmp;
      opRegimm:
        if (instr[20:16] == rtBgez || instr[20:16] == rtBltz)
          expClass = clsBranchZero;
      opJ:     expClass = clsJump;
      opJal:   expClass = clsJumpLink;
      opLw:    expClass = clsLoad;
      opSw:    expClass = clsStore;
      default: expClass = clsNone;
    endcase
  end

  // code table of the ALU station
  always_comb
  begin
    case (op)
      opAndi:  expAluOp = aluAnd;
      opOri:   expAluOp = aluOr;
      opXori:  expAluOp = aluXor;
      opSlti:  expAluOp = aluSlt;
      opSltiu: expAluOp = aluSltu;
      opRtype:
        case (fn)
          fnSubu:  expAluOp = aluSub;
          fnAnd:   expAluOp = aluAnd;
          fnOr:    expAluOp = aluOr;
          fnXor:   expAluOp = aluXor;
          fnSlt:   expAluOp = aluSlt;
          fnSltu:  expAluOp = aluSltu;
          fnSll:   expAluOp = aluSll;
          fnSrl:   expAluOp = aluSrl;
          fnSra:   expAluOp = aluSra;
          default: expAluOp = aluAdd;
        endcase
      default: expAluOp = aluAdd; // addu, addiu, lui, jal
    endcase
  end

  assign aluCls = expClass inside {clsAluReg, clsAluImm, clsLui, clsShift};
  assign brCls  = expClass inside {clsBranchCmp, clsBranchZero};
  assign usesRs = aluCls && expClass != clsShift && expClass != clsLui ||
                  brCls || expClass inside {clsJumpReg, clsLoad, clsStore};
  assign usesRt = expClass inside {clsAluReg, clsShift, clsBranchCmp, clsStore};

  assign expWriteReg = (expClass == clsAluReg || expClass == clsShift) ? instr[15:11] :
                       (expClass inside {clsAluImm, clsLui, clsLoad}) ? instr[20:16] :
                       (expClass == clsJumpLink) ? linkReg : 5'd0;
  assign expBranchOp = (expClass == clsJumpLink) ? brJal : (expClass == clsJumpReg) ? brJr :
                       (expClass == clsJump) ? brJ : brNone;
  assign expImm = (expClass == clsLui) ? {imm, 16'h0000} :
                  (op == opAndi || op == opOri || op == opXori) ? {16'h0000, imm} :
                  {{16{imm[15]}}, imm};

  // register file, then ready ROB entry, then same-cycle CDB
  assign expRsTag = (rsReorder == '0 || rsRobReady || (cdbValid && cdbTag == rsReorder))
                    ? 5'd0 : rsReorder;
  assign expRsVal = (rsReorder == '0) ? rsData : rsRobReady ? rsRobValue :
                    (cdbValid && cdbTag == rsReorder) ? cdbValue : 32'd0;
  assign expRtTag = (rtReorder == '0 || rtRobReady || (cdbValid && cdbTag == rtReorder))
                    ? 5'd0 : rtReorder;
  assign expRtVal = (rtReorder == '0) ? rtData : rtRobReady ? rtRobValue :
                    (cdbValid && cdbTag == rtReorder) ? cdbValue : 32'd0;
  assign expQj = usesRs ? expRsTag : 5'd0;
  assign expQk = usesRt ? expRtTag : 5'd0;

  assign expSelFull = aluCls ? aluFull : brCls ? branchFull :
                      (expClass == clsLoad) ? loadFull :
                      (expClass == clsStore) ? storeFull : 1'b0;
  assign expJrStall = (expClass == clsJumpReg) && (expRsTag != '0);
  assign expIssue   = !stall && !robFull && !expSelFull && !rollback && !prevBlock &&
                      !expJrStall && (expClass != clsNone);
  assign expStations = {expIssue && (aluCls || expClass == clsJumpLink) && expWriteReg != '0,
                        expIssue && brCls,
                        expIssue && expClass == clsLoad && expWriteReg != '0,
                        expIssue && expClass == clsStore};
  assign expRegStat = expIssue && (aluCls || expClass inside {clsJumpLink, clsLoad});
  assign stations = {aluIssue, branchIssue, loadIssue, storeIssue};

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      prevBlock <= 1'b1;
    else
      prevBlock <= rollback;
  end

  aluOpMatches: assert property (@(posedge clk) disable iff (!rstN)
      (aluCls || expClass == clsJumpLink) |-> aluOp == expAluOp)
    else countFailure("aluOp", 32'($sampled(aluOp)), 32'($sampled(expAluOp)));
  writeRegMatches: assert property (@(posedge clk) disable iff (!rstN)
      writeReg == expWriteReg)
    else countFailure("writeReg", 32'($sampled(writeReg)), 32'($sampled(expWriteReg)));
  srcFieldsMatch: assert property (@(posedge clk) disable iff (!rstN)
      {rs, rt} == instr[25:16])
    else countFailure("rs/rt", 32'($sampled({rs, rt})), 32'($sampled(instr[25:16])));
  immMatches: assert property (@(posedge clk) disable iff (!rstN)
      (expClass == clsAluImm || expClass == clsLui) |-> vk == expImm)
    else countFailure("vk", $sampled(vk), $sampled(expImm));
  rsValueMatches: assert property (@(posedge clk) disable iff (!rstN)
      usesRs |-> vj == expRsVal)
    else countFailure("vj", $sampled(vj), $sampled(expRsVal));
  rsTagMatches: assert property (@(posedge clk) disable iff (!rstN)
      qj == expQj)
    else countFailure("qj", 32'($sampled(qj)), 32'($sampled(expQj)));
  rtValueMatches: assert property (@(posedge clk) disable iff (!rstN)
      usesRt |-> vk == expRtVal)
    else countFailure("vk", $sampled(vk), $sampled(expRtVal));
  rtTagMatches: assert property (@(posedge clk) disable iff (!rstN)
      qk == expQk)
    else countFailure("qk", 32'($sampled(qk)), 32'($sampled(expQk)));
  robIssueMatches: assert property (@(posedge clk) disable iff (!rstN)
      robIssue == expIssue)
    else countFailure("robIssue", 32'($sampled(robIssue)), 32'($sampled(expIssue)));
  regStatMatches: assert property (@(posedge clk) disable iff (!rstN)
      regStatIssue == expRegStat)
    else countFailure("regStatIssue", 32'($sampled(regStatIssue)),
                      32'($sampled(expRegStat)));
  stationsMatch: assert property (@(posedge clk) disable iff (!rstN)
      stations == expStations)
    else countFailure("stationIssue", 32'($sampled(stations)), 32'($sampled(expStations)));
  rsBusyMatches: assert property (@(posedge clk) disable iff (!rstN)
      rsBusy == (expSelFull || robFull))
    else countFailure("rsBusy", 32'($sampled(rsBusy)), 32'($sampled(expSelFull || robFull)));
  entryReadyMatches: assert property (@(posedge clk) disable iff (!rstN)
      robEntryReady == !(|expStations))
    else countFailure("robEntryReady", 32'($sampled(robEntryReady)),
                      32'($sampled(!(|expStations))));
  addrImmMatches: assert property (@(posedge clk) disable iff (!rstN)
      (expClass == clsLoad || expClass == clsStore) |-> addrImm == imm)
    else countFailure("addrImm", 32'($sampled(addrImm)), 32'($sampled(imm)));
  jalLinkPc: assert property (@(posedge clk) disable iff (!rstN)
      expClass == clsJumpLink |-> vj == pc)
    else countFailure("vj", $sampled(vj), $sampled(pc));
  jalLinkOffset8: assert property (@(posedge clk) disable iff (!rstN)
      expClass == clsJumpLink |-> vk == 32'd8)
    else countFailure("vk", $sampled(vk), 32'd8);
  branchOpMatches: assert property (@(posedge clk) disable iff (!rstN)
      branchOp == expBranchOp)
    else countFailure("branchOp", 32'($sampled(branchOp)), 32'($sampled(expBranchOp)));
  jrStallMatches: assert property (@(posedge clk) disable iff (!rstN)
      jrStall == expJrStall)
    else countFailure("jrStall", 32'($sampled(jrStall)), 32'($sampled(expJrStall)));

endmodule

// ==== test/tbDispatch.sv ====
/* tbDispatch
   random and directed stimulus for the dispatch stage
   results are compared by the bound checker */
`timescale 1ns/1ps

module tbDispatch import isaPkg::*, dispatchPkg::*; ();

  logic     clk;
  logic     rstN;
  instrWord instr;
  dataWord  pc;
  logic     stall;
  logic     rollback;
  logic     robFull, aluFull, branchFull, loadFull, storeFull; // back-pressure levels
  robTag    rsReorder, rtReorder, cdbTag;
  dataWord  rsData, rtData, rsRobValue, rtRobValue, cdbValue;
  logic     rsRobReady, rtRobReady, cdbValid;
  regIdx    rs, rt, writeReg;
  logic     robIssue, regStatIssue, aluIssue, branchIssue, loadIssue, storeIssue;
  logic     jrStall, robEntryReady, rsBusy;
  dataWord  vj, vk;
  robTag    qj, qk;
  immT      addrImm;
  aluOpT    aluOp;
  branchOpT branchOp;
  int       cycles = 0;

  dispatchUnit i_dispatchUnit (.*);

  bind dispatchUnit dispatchUnitAssertions i_checks (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  always @(posedge clk)
    cycles++;

  // run limit well above the 617 cycles of stimulus
  initial
  begin
    wait (cycles >= 1000);
    $display("timeout: stimulus did not finish within %0d cycles", cycles);
    $display("Done: errors found");
    $finish;
  end

  // one instruction of the given kind with random register fields
  function automatic instrWord makeInstr(input int kind);
    regIdx rsF, rtF, rdF;
    shamtT sh;
    immT   imm;
    rsF = 5'($urandom);
    rtF = ($urandom % 8 == 0) ? 5'd0 : 5'($urandom); // zero destination now and then
    rdF = ($urandom % 8 == 0) ? 5'd0 : 5'($urandom);
    sh  = 5'($urandom);
    imm = 16'($urandom);
    case (kind)
      0:  return {opRtype, rsF, rtF, rdF, 5'd0, fnAddu};
      1:  return {opRtype, rsF, rtF, rdF, 5'd0, fnSubu};
      2:  return {opRtype, rsF, rtF, rdF, 5'd0, fnAnd};
      3:  return {opRtype, rsF, rtF, rdF, 5'd0, fnOr};
      4:  return {opRtype, rsF, rtF, rdF, 5'd0, fnXor};
      5:  return {opRtype, rsF, rtF, rdF, 5'd0, fnSlt};
      6:  return {opRtype, rsF, rtF, rdF, 5'd0, fnSltu};
      7:  return {opRtype, 5'd0, rtF, rdF, sh, fnSll};
      8:  return {opRtype, 5'd0, rtF, rdF, sh, fnSrl};
      9:  return {opRtype, 5'd0, rtF, rdF, sh, fnSra};
      10: return {opAddiu, rsF, rtF, imm};
      11: return {opAndi, rsF, rtF, imm};
      12: return {opOri, rsF, rtF, imm};
      13: return {opXori, rsF, rtF, imm};
      14: return {opSlti, rsF, rtF, imm};
      15: return {opSltiu, rsF, rtF, imm};
      16: return {opLui, 5'd0, rtF, imm};
      17: return {opBeq, rsF, rtF, imm};
      18: return {opBne, rsF, rtF, imm};
      19: return {opRegimm, rsF, rtBgez, imm};
      20: return {opRegimm, rsF, rtBltz, imm};
      21: return {opJ, 26'($urandom)};
      22: return {opJal, 26'($urandom)};
      23: return {opRtype, rsF, 15'd0, fnJr};
      24: return {opLw, rsF, rtF, imm};
      25: return {opSw, rsF, rtF, imm};
      default: return {6'b111111, 26'($urandom)}; // unused opcode, decodes as none
    endcase
  endfunction

  // lookup results, CDB traffic and back-pressure for the next cycle
  task automatic driveSideInputs();
    robTag tagA, tagB;
    tagA = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
    tagB = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
    rsReorder  <= tagA;
    rtReorder  <= tagB;
    rsData     <= $urandom;
    rtData     <= $urandom;
    rsRobReady <= ($urandom % 4 == 0);
    rtRobReady <= ($urandom % 4 == 0);
    rsRobValue <= $urandom;
    rtRobValue <= $urandom;
    cdbValid   <= ($urandom % 2 == 0);
    cdbTag     <= ($urandom % 2 == 0) ? tagA : tagB; // often hits a waiting source
    cdbValue   <= $urandom;
    stall      <= ($urandom % 12 == 0);
    rollback   <= ($urandom % 25 == 0);
    robFull    <= ($urandom % 10 == 0);
    aluFull    <= ($urandom % 8 == 0);
    branchFull <= ($urandom % 8 == 0);
    loadFull   <= ($urandom % 8 == 0);
    storeFull  <= ($urandom % 8 == 0);
  endtask

  initial
  begin
    int held;
    void'($urandom(32'h7341c30d));
    rstN = 1'b0;
    instr = '0;
    pc = 32'h0040_0000;
    stall = 1'b0;
    rollback = 1'b0;
    {robFull, aluFull, branchFull, loadFull, storeFull} = '0;
    {rsReorder, rtReorder, cdbTag} = '0;
    {rsData, rtData, rsRobValue, rtRobValue, cdbValue} = '0;
    {rsRobReady, rtRobReady, cdbValid} = '0;
    held = 0;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;
    repeat (600)
    begin
      @(posedge clk);
      // advance on issue or after 8 held cycles since class none never issues
      if (robIssue || held >= 8)
      begin
        instr <= makeInstr(int'($urandom % 27));
        pc    <= pc + 32'd4;
        held  = 0;
      end
      else
        held++;
      driveSideInputs();
    end
    @(posedge clk); // last stimulus gets sampled
    @(negedge clk); // checker action blocks of that edge have run
    $display("assertion failures: %0d", i_dispatchUnit.i_checks.errCount);
    if (i_dispatchUnit.i_checks.errCount == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== src.f ====
source/isaPkg.sv
source/dispatchPkg.sv
source/instrDecoder.sv
source/sourceResolver.sv
source/operandSelect.sv
source/issueControl.sv
source/dispatchUnit.sv
test/dispatchUnit_assertions.sv
test/tbDispatch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the dispatch stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f --top-module tbDispatch \
  -o simDispatch || { echo "build failed"; exit 1; }
./obj_dir/simDispatch +verilator+error+limit+100000 > sim.log 2>&1 || echo "simulator exit nonzero"
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
